// ==== hw/bru_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Branch resolution package
// Operation and control flow type encodings shared by the execute stage
// branch logic, plus a helper that marks the conditional branches
////////////////////////////////////////////////////////////////////////////

package bru_pkg;

  // Encoding widths of the two enums
  localparam int unsigned BRANCH_OP_W = 4;
  localparam int unsigned CF_TYPE_W   = 2;

  // Operation presented by the issue stage
  typedef enum logic [BRANCH_OP_W-1:0] {
    OP_NONE = 4'd0,
    // Conditional branches
    BEQ     = 4'd1,
    BNE     = 4'd2,
    BLT     = 4'd3,
    BGE     = 4'd4,
    BLTU    = 4'd5,
    BGEU    = 4'd6,
    // Unconditional jumps
    JAL     = 4'd7,
    JALR    = 4'd8
  } branch_op_e;

  // Control flow type, used for both the prediction and the resolution
  typedef enum logic [CF_TYPE_W-1:0] {
    // Not a control flow instruction, or no prediction made
    CF_NONE   = 2'd0,
    CF_BRANCH = 2'd1,
    // Jump through a register, BTB target
    CF_JUMPR  = 2'd2,
    // Return, predicted by the return stack
    CF_RETURN = 2'd3
  } cf_type_e;

  // True for the six conditional branch operations
  function automatic logic op_is_branch(branch_op_e op);
    logic is_br;
    case (op)
      BEQ, BNE, BLT, BGE, BLTU, BGEU: is_br = 1'b1;
      default: is_br = 1'b0;
    endcase
    return is_br;
  endfunction

endpackage

// ==== hw/branch_compare.sv ====
////////////////////////////////////////////////////////////////////////////
// Branch operand comparator
// Evaluates the branch condition for the six conditional operations.
// Jumps always report taken
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module branch_compare #(
  parameter int unsigned VLEN = 32
) (
  // Operation from the issue stage
  input  bru_pkg::branch_op_e op_i,
  // Register operands rs1 and rs2
  input  logic [VLEN-1:0]     a_i,
  input  logic [VLEN-1:0]     b_i,
  // Branch condition, 1 for jumps
  output logic                taken_o
);

  logic eq;
  logic lt_signed;
  logic lt_unsigned;

  // All three compares run in parallel, the operation picks one
  assign eq          = (a_i == b_i);
  assign lt_signed   = ($signed(a_i) < $signed(b_i));
  assign lt_unsigned = (a_i < b_i);

  always_comb begin
    taken_o = 1'b0;
    if (bru_pkg::op_is_branch(op_i)) begin
      case (op_i)
        bru_pkg::BEQ:  taken_o = eq;
        bru_pkg::BNE:  taken_o = !eq;
        bru_pkg::BLT:  taken_o = lt_signed;
        bru_pkg::BGE:  taken_o = !lt_signed;
        bru_pkg::BLTU: taken_o = lt_unsigned;
        bru_pkg::BGEU: taken_o = !lt_unsigned;
        default:       taken_o = 1'b0;
      endcase
    end else begin
      // Unconditional jumps always redirect
      taken_o = (op_i == bru_pkg::JAL) || (op_i == bru_pkg::JALR);
    end
  end

endmodule

// ==== hw/branch_history.sv ====
////////////////////////////////////////////////////////////////////////////
// Branch history table
// Direct mapped table of 2-bit saturating counters indexed by PC.
// Lookup is combinational, training happens at the clock edge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module branch_history #(
  parameter int unsigned VLEN        = 32,
  parameter int unsigned BHT_ENTRIES = 16
) (
  input  logic            clk_i,
  input  logic            reset_i,
  // Prediction port, PC of the instruction being resolved
  input  logic [VLEN-1:0] lookup_pc_i,
  output logic            predict_taken_o,
  // Training port from the branch unit
  input  logic            update_valid_i,
  input  logic [VLEN-1:0] update_pc_i,
  input  logic            update_taken_i
);

  // Index width, table size is a power of two
  localparam int unsigned IDX_W = $clog2(BHT_ENTRIES);

  // Counter encodings
  localparam logic [1:0] CNT_STRONG_NT = 2'b00;
  localparam logic [1:0] CNT_WEAK_NT   = 2'b01;
  localparam logic [1:0] CNT_STRONG_T  = 2'b11;

  logic [1:0]       counters_q [BHT_ENTRIES];
  logic [IDX_W-1:0] lookup_idx;
  logic [IDX_W-1:0] update_idx;
  logic [1:0]       update_cnt;
  logic [1:0]       update_cnt_next;

  // Index taken from the PC bits right above bit 1
  assign lookup_idx = lookup_pc_i[IDX_W+1:2];
  assign update_idx = update_pc_i[IDX_W+1:2];

  // Upper counter bit is the taken prediction
  assign predict_taken_o = counters_q[lookup_idx][1];

  assign update_cnt = counters_q[update_idx];

  // Step toward the outcome, hold at either end
  always_comb begin
    update_cnt_next = update_cnt;
    if (update_taken_i) begin
      if (update_cnt != CNT_STRONG_T) begin
        update_cnt_next = update_cnt + 2'd1;
      end
    end else begin
      if (update_cnt != CNT_STRONG_NT) begin
        update_cnt_next = update_cnt - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // Every entry starts weakly not taken
      for (int i = 0; i < BHT_ENTRIES; i++) begin
        counters_q[i] <= CNT_WEAK_NT;
      end
    end else if (update_valid_i) begin
      counters_q[update_idx] <= update_cnt_next;
    end
  end

endmodule

// ==== hw/branch_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// Branch unit
// Computes link value and jump target, resolves taken and mispredict,
// reports the control flow type and flags misaligned targets
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module branch_unit #(
  parameter int unsigned VLEN   = 32,
  parameter bit          RVC_EN = 1'b1
) (
  // Issue stage instruction
  input  logic                valid_i,
  input  bru_pkg::branch_op_e op_i,
  input  logic [VLEN-1:0]     pc_i,
  input  logic [VLEN-1:0]     operand_a_i,
  input  logic [VLEN-1:0]     imm_i,
  input  logic                is_compressed_i,
  // Condition from the comparator
  input  logic                branch_taken_i,
  // Direction prediction from the history table
  input  logic                predict_taken_i,
  // Register jump prediction from BTB and return stack
  input  bru_pkg::cf_type_e   predict_cf_i,
  input  logic [VLEN-1:0]     predict_addr_i,
  // Resolution
  output logic [VLEN-1:0]     result_o,
  output logic                resolve_o,
  output logic [VLEN-1:0]     target_o,
  output logic                taken_o,
  output logic                mispredict_o,
  output bru_pkg::cf_type_e   cf_type_o,
  output logic                misaligned_o,
  // History table training
  output logic                update_valid_o,
  output logic                update_taken_o
);

  // Forbidden low target bits, bit 0 only when compressed code is allowed
  localparam logic [1:0] ALIGN_MASK = RVC_EN ? 2'b01 : 2'b11;

  logic [VLEN-1:0] next_pc;
  logic [VLEN-1:0] jump_base;
  logic [VLEN-1:0] jump_target;
  logic            is_branch;
  logic            is_jalr;
  logic            target_unaligned;

  assign is_branch = bru_pkg::op_is_branch(op_i);
  assign is_jalr   = (op_i == bru_pkg::JALR);

  // Fall-through PC, also the link value written to rd
  assign next_pc  = pc_i + (is_compressed_i ? VLEN'(2) : VLEN'(4));
  assign result_o = next_pc;

  // Register base for JALR, PC relative otherwise
  assign jump_base = is_jalr ? operand_a_i : pc_i;

  always_comb begin
    jump_target = jump_base + imm_i;
    // JALR drops the LSB of the sum
    if (is_jalr) begin
      jump_target[0] = 1'b0;
    end
  end

  assign target_unaligned = |(jump_target[1:0] & ALIGN_MASK);

  always_comb begin
    resolve_o    = valid_i;
    target_o     = '0;
    taken_o      = 1'b0;
    mispredict_o = 1'b0;
    cf_type_o    = bru_pkg::CF_NONE;
    misaligned_o = 1'b0;
    if (valid_i) begin
      taken_o  = branch_taken_i;
      target_o = branch_taken_i ? jump_target : next_pc;
      // Only a redirect can fault on alignment
      misaligned_o = branch_taken_i && target_unaligned;
      if (is_branch) begin
        cf_type_o    = bru_pkg::CF_BRANCH;
        // Direction disagrees with the counter
        mispredict_o = (branch_taken_i != predict_taken_i);
      end else if (is_jalr) begin
        cf_type_o = predict_cf_i;
        // No prediction, or the predicted address was wrong
        if ((predict_cf_i == bru_pkg::CF_NONE) || (jump_target != predict_addr_i)) begin
          mispredict_o = 1'b1;
          // Returns keep their type so the BTB is not updated
          if (predict_cf_i != bru_pkg::CF_RETURN) begin
            cf_type_o = bru_pkg::CF_JUMPR;
          end
        end
      end
    end
  end

  // Train only on resolved conditional branches
  assign update_valid_o = valid_i && is_branch;
  assign update_taken_o = branch_taken_i;

endmodule

// ==== hw/branch_resolve_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Branch resolution top level
// Joins the operand comparator, the history table and the branch unit
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module branch_resolve_top #(
  parameter int unsigned VLEN        = 32,
  parameter int unsigned BHT_ENTRIES = 16,
  parameter bit          RVC_EN      = 1'b1
) (
  input  logic                clk_i,
  input  logic                reset_i,
  // Issue stage
  input  logic                valid_i,
  input  bru_pkg::branch_op_e op_i,
  input  logic [VLEN-1:0]     pc_i,
  input  logic [VLEN-1:0]     operand_a_i,
  input  logic [VLEN-1:0]     operand_b_i,
  input  logic [VLEN-1:0]     imm_i,
  input  logic                is_compressed_i,
  // Register jump prediction, JALR only
  input  bru_pkg::cf_type_e   predict_cf_i,
  input  logic [VLEN-1:0]     predict_addr_i,
  // Resolution
  output logic [VLEN-1:0]     result_o,
  output logic                resolve_o,
  output logic [VLEN-1:0]     resolved_pc_o,
  output logic [VLEN-1:0]     target_o,
  output logic                taken_o,
  output logic                mispredict_o,
  output bru_pkg::cf_type_e   cf_type_o,
  output logic                misaligned_o
);

  logic branch_taken;
  logic predict_taken;
  logic update_valid;
  logic update_taken;

  // PC of the resolved instruction goes back with the result
  assign resolved_pc_o = pc_i;

  branch_compare #(
    .VLEN (VLEN)
  ) u_compare (
    .op_i    (op_i),
    .a_i     (operand_a_i),
    .b_i     (operand_b_i),
    .taken_o (branch_taken)
  );

  // Lookup and training use the same PC, the update lands at the edge
  branch_history #(
    .VLEN        (VLEN),
    .BHT_ENTRIES (BHT_ENTRIES)
  ) u_history (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .lookup_pc_i     (pc_i),
    .predict_taken_o (predict_taken),
    .update_valid_i  (update_valid),
    .update_pc_i     (pc_i),
    .update_taken_i  (update_taken)
  );

  branch_unit #(
    .VLEN   (VLEN),
    .RVC_EN (RVC_EN)
  ) u_unit (
    .valid_i         (valid_i),
    .op_i            (op_i),
    .pc_i            (pc_i),
    .operand_a_i     (operand_a_i),
    .imm_i           (imm_i),
    .is_compressed_i (is_compressed_i),
    .branch_taken_i  (branch_taken),
    .predict_taken_i (predict_taken),
    .predict_cf_i    (predict_cf_i),
    .predict_addr_i  (predict_addr_i),
    .result_o        (result_o),
    .resolve_o       (resolve_o),
    .target_o        (target_o),
    .taken_o         (taken_o),
    .mispredict_o    (mispredict_o),
    .cf_type_o       (cf_type_o),
    .misaligned_o    (misaligned_o),
    .update_valid_o  (update_valid),
    .update_taken_o  (update_taken)
  );

endmodule

// ==== test/branch_resolve_props.sv ====
////////////////////////////////////////////////////////////////////////////
// Branch resolution properties
// Concurrent checks on the resolve pulse, the idle flags and the link value
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module branch_resolve_props #(
  parameter int unsigned VLEN = 32
) (
  input logic            clk_i,
  input logic            reset_i,
  input logic            valid_i,
  input logic [VLEN-1:0] pc_i,
  input logic            is_compressed_i,
  input logic [VLEN-1:0] result_i,
  input logic            resolve_i,
  input logic            taken_i,
  input logic            mispredict_i,
  input logic            misaligned_i
);

  // Number of failed properties, read by the testbench at the end of the run
  int unsigned assert_fail_count = 0;

  // Resolve pulse is the valid strobe, same cycle
  resolve_matches_valid: assert property (
    @(posedge clk_i) disable iff (reset_i) resolve_i == valid_i
  ) else begin
    assert_fail_count++;
    $error("resolve pulse does not follow valid");
  end

  // Idle cycles raise no flag
  idle_flags_low: assert property (
    @(posedge clk_i) disable iff (reset_i)
      !valid_i |-> !(taken_i || mispredict_i || misaligned_i)
  ) else begin
    assert_fail_count++;
    $error("taken, mispredict or misaligned set without valid");
  end

  // Compressed instruction links to pc plus 2
  compressed_link: assert property (
    @(posedge clk_i) disable iff (reset_i)
      is_compressed_i |-> (result_i == pc_i + VLEN'(2))
  ) else begin
    assert_fail_count++;
    $error("compressed link value is not pc plus 2");
  end

endmodule

bind branch_resolve_top branch_resolve_props #(
  .VLEN (VLEN)
) u_props (
  .clk_i           (clk_i),
  .reset_i         (reset_i),
  .valid_i         (valid_i),
  .pc_i            (pc_i),
  .is_compressed_i (is_compressed_i),
  .result_i        (result_o),
  .resolve_i       (resolve_o),
  .taken_i         (taken_o),
  .mispredict_i    (mispredict_o),
  .misaligned_i    (misaligned_o)
);

// ==== test/tb_branch_resolve.sv ====
////////////////////////////////////////////////////////////////////////////
// Branch resolution testbench
// Reads named vectors from the tests file, drives the DUT one instruction
// per cycle and compares every resolved output with the expected value
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_branch_resolve;

  localparam int unsigned VLEN = 32;
  localparam int RESET_TIMEOUT = 20;
  localparam int MAX_LINES     = 500;

  logic                clk;
  logic                reset;
  logic                valid;
  bru_pkg::branch_op_e op;
  logic [VLEN-1:0]     pc;
  logic [VLEN-1:0]     operand_a;
  logic [VLEN-1:0]     operand_b;
  logic [VLEN-1:0]     imm;
  logic                is_compressed;
  bru_pkg::cf_type_e   predict_cf;
  logic [VLEN-1:0]     predict_addr;
  logic [VLEN-1:0]     result;
  logic                resolve;
  logic [VLEN-1:0]     resolved_pc;
  logic [VLEN-1:0]     target;
  logic                taken;
  logic                mispredict;
  bru_pkg::cf_type_e   cf_type;
  logic                misaligned;

  // Fields of the current vector, inputs first, then expected outputs
  string       test_name;
  logic [31:0] f_valid;
  logic [31:0] f_op;
  logic [31:0] f_pc;
  logic [31:0] f_a;
  logic [31:0] f_b;
  logic [31:0] f_imm;
  logic [31:0] f_comp;
  logic [31:0] f_pcf;
  logic [31:0] f_paddr;
  logic [31:0] e_result;
  logic [31:0] e_target;
  logic [31:0] e_taken;
  logic [31:0] e_mispredict;
  logic [31:0] e_cf;
  logic [31:0] e_misaligned;

  int test_errors;
  int pass_count;
  int fail_count;
  bit released;
  bit file_ok;

  branch_resolve_top #(
    .VLEN        (VLEN),
    .BHT_ENTRIES (16),
    .RVC_EN      (1'b1)
  ) dut (
    .clk_i           (clk),
    .reset_i         (reset),
    .valid_i         (valid),
    .op_i            (op),
    .pc_i            (pc),
    .operand_a_i     (operand_a),
    .operand_b_i     (operand_b),
    .imm_i           (imm),
    .is_compressed_i (is_compressed),
    .predict_cf_i    (predict_cf),
    .predict_addr_i  (predict_addr),
    .result_o        (result),
    .resolve_o       (resolve),
    .resolved_pc_o   (resolved_pc),
    .target_o        (target),
    .taken_o         (taken),
    .mispredict_o    (mispredict),
    .cf_type_o       (cf_type),
    .misaligned_o    (misaligned)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reset held for two rising edges
  initial begin
    reset <= 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  end

  // At least one edge passes before reset is looked at
  task automatic wait_reset_release(output bit done);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (reset !== 1'b0 && cycles < RESET_TIMEOUT);
    done = (reset === 1'b0);
  endtask

  task automatic check_value(input string field, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("error %0s %0s expected %h actual %h", test_name, field, expected, actual);
      test_errors++;
    end
  endtask

  // One instruction per cycle, outputs sampled at the falling edge
  task automatic apply_test();
    @(posedge clk);
    valid         <= f_valid[0];
    op            <= bru_pkg::branch_op_e'(f_op[3:0]);
    pc            <= f_pc;
    operand_a     <= f_a;
    operand_b     <= f_b;
    imm           <= f_imm;
    is_compressed <= f_comp[0];
    predict_cf    <= bru_pkg::cf_type_e'(f_pcf[1:0]);
    predict_addr  <= f_paddr;
    @(negedge clk);
    test_errors = 0;
    check_value("result", e_result, result);
    check_value("resolve", 32'(f_valid[0]), 32'(resolve));
    check_value("resolved_pc", f_pc, resolved_pc);
    check_value("target", e_target, target);
    check_value("taken", e_taken, 32'(taken));
    check_value("mispredict", e_mispredict, 32'(mispredict));
    check_value("cf_type", e_cf, 32'(cf_type));
    check_value("misaligned", e_misaligned, 32'(misaligned));
    if (test_errors == 0) begin
      pass_count++;
      $display("%0s: ok", test_name);
    end else begin
      fail_count++;
      $display("%0s: mismatch", test_name);
    end
  endtask

  task automatic run_test_file(output bit ok);
    int    fd;
    int    code;
    int    lines;
    string line;
    ok = 1'b1;
    fd = $fopen("test/branch_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the test vector file");
      ok = 1'b0;
    end else begin
      lines = 0;
      while (!$feof(fd) && lines < MAX_LINES) begin
        code = $fgets(line, fd);
        lines++;
        // Skip blank lines and column comments
        if (code > 0 && line.getc(0) != "#") begin
          code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         test_name, f_valid, f_op, f_pc, f_a, f_b, f_imm, f_comp,
                         f_pcf, f_paddr, e_result, e_target, e_taken,
                         e_mispredict, e_cf, e_misaligned);
          if (code == 16) begin
            apply_test();
          end else if (code > 0) begin
            $display("malformed vector on line %0d", lines);
            ok = 1'b0;
          end
        end
      end
      if (!$feof(fd)) begin
        $display("reading the vector file did not finish within %0d lines", MAX_LINES);
        ok = 1'b0;
      end
      $fclose(fd);
    end
  endtask

  initial begin
    valid         <= 1'b0;
    op            <= bru_pkg::OP_NONE;
    pc            <= '0;
    operand_a     <= '0;
    operand_b     <= '0;
    imm           <= '0;
    is_compressed <= 1'b0;
    predict_cf    <= bru_pkg::CF_NONE;
    predict_addr  <= '0;
    pass_count = 0;
    fail_count = 0;
    wait_reset_release(released);
    if (!released) begin
      $display("reset was not released in time");
      $display("tests failed");
      $finish;
    end else begin
      run_test_file(file_ok);
      $display("%0d run, %0d passed, %0d failed, %0d assertion failures",
               pass_count + fail_count, pass_count, fail_count,
               dut.u_props.assert_fail_count);
      if (file_ok && fail_count == 0 && pass_count > 0 &&
          dut.u_props.assert_fail_count == 0) begin
        $display("all tests passed");
      end else begin
        $display("tests failed");
      end
      $finish;
    end
  end

endmodule

// ==== test/branch_tests.txt ====
# name valid op pc operand_a operand_b imm compressed pred_cf pred_addr, all hex
# then expected result target taken mispredict cf_type misaligned
beq_taken 1 1 1000 5 5 20 0 0 0 1004 1020 1 1 1 0
bne_not_taken 1 2 1004 5 5 40 0 0 0 1008 1008 0 0 1 0
blt_signed_taken 1 3 1008 ffffffff 1 fffffff0 0 0 0 100c ff8 1 1 1 0
bltu_not_taken 1 5 100c ffffffff 1 20 0 0 0 1010 1010 0 0 1 0
bge_not_taken 1 4 1010 ffffffff 1 20 0 0 0 1014 1014 0 0 1 0
bgeu_taken 1 6 1014 ffffffff 1 100 0 0 0 1018 1114 1 1 1 0
train_taken_1 1 1 2020 7 7 80 0 0 0 2024 20a0 1 1 1 0
train_taken_2 1 1 2020 7 7 80 0 0 0 2024 20a0 1 0 1 0
train_taken_3 1 1 2020 7 7 80 0 0 0 2024 20a0 1 0 1 0
train_other_index 1 2 2024 1 2 80 0 0 0 2028 20a4 1 1 1 0
train_not_taken 1 1 2020 7 8 80 0 0 0 2024 2024 0 1 1 0
jalr_clear_bit0 1 8 3000 4001 0 10 0 2 4010 3004 4010 1 0 2 0
jalr_wrong_addr 1 8 3004 4000 0 8 0 2 4010 3008 4008 1 1 2 0
jalr_no_predict 1 8 3008 5000 0 0 0 0 0 300c 5000 1 1 2 0
jalr_return_hit 1 8 300c 6000 0 0 0 3 6000 3010 6000 1 0 3 0
jalr_return_miss 1 8 3010 6000 0 4 0 3 6000 3014 6004 1 1 3 0
jal_link 1 7 4000 0 0 100 0 0 0 4004 4100 1 0 0 0
jal_compressed 1 7 4002 0 0 10 1 0 0 4004 4012 1 0 0 0
bne_nt_compressed 1 2 4006 3 3 20 1 0 0 4008 4008 0 0 1 0
jal_odd_imm 1 7 5000 0 0 11 0 0 0 5004 5011 1 0 0 1
beq_nt_odd_target 1 1 5004 1 2 9 0 0 0 5008 5008 0 0 1 0
idle_branch 0 1 1000 1 2 20 0 0 0 1004 0 0 0 0 0
after_idle_branch 1 1 1000 1 1 20 0 0 0 1004 1020 1 0 1 0

// ==== verilog.f ====
hw/bru_pkg.sv
hw/branch_compare.sv
hw/branch_history.sv
hw/branch_unit.sv
hw/branch_resolve_top.sv
test/branch_resolve_props.sv
test/tb_branch_resolve.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_branch_resolve -f verilog.f -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "tests failed" sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
